// File: cpu_consts.svh
//##########################################################################
// processor widths and constants
//##########################################################################
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address word
`define WORD_W 32

// register index into the 32 entry file
`define REG_W 5

// i-type immediate field
`define IMM_W 16

// r-type shift amount field
`define SHAM_W 5

// first fetch address out of reset
`define PC_INIT 32'h0000_0000

// all ones word stops the core
`define HALT_INSTR 32'hFFFF_FFFF

`endif

// File: cpuTypesPkg.sv
//##########################################################################
// processor types
//##########################################################################
`include "cpu_consts.svh"

package cpuTypesPkg;

  // widths with a meaning
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_W-1:0]  regBits_t;
  typedef logic [`IMM_W-1:0]  imm_t;

  // major opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'h00, ADDIU = 6'h09, SLTI = 6'h0A,
    ANDI  = 6'h0C, ORI   = 6'h0D, XORI = 6'h0E,
    LUI   = 6'h0F, LW    = 6'h23, SW   = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    SLL = 6'h00, SRL = 6'h02, ADDU = 6'h21,
    SUBU = 6'h23, AND = 6'h24, OR = 6'h25,
    XOR = 6'h26, NOR = 6'h27, SLT = 6'h2A
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
  } aluOp_t;

  typedef enum logic {RT, RD} regDst_t;
  typedef enum logic {ALUO, DLOAD} memToReg_t;
  typedef enum logic [1:0] {ZEROEXT, SIGNEXT, SHAMEXT} extOp_t;

  // execute operand source
  typedef enum logic [1:0] {FREG, FMM, FWB} fwdSel_t;

  // decoded controls, carried into execute
  typedef struct packed {
    regDst_t   regDst;
    logic      aluSrc;
    memToReg_t memToReg;
    logic      regWen;
    logic      dRen;
    logic      dWen;
    aluOp_t    aluOp;
    extOp_t    extOp;
    logic      halt;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
  } ifId_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    regBits_t                rs;
    regBits_t                rt;
    regBits_t                rd;
    logic [`SHAM_W-1:0]      shamt;
    imm_t                    imm;
    word_t                   busA;
    word_t                   busB;
  } idEx_t;

  typedef struct packed {
    memToReg_t memToReg;
    logic      regWen;
    logic      dRen;
    logic      dWen;
    logic      halt;
    regBits_t  rd;
    word_t     aluOut;
    word_t     store;
  } exMm_t;

  typedef struct packed {
    memToReg_t memToReg;
    logic      regWen;
    logic      halt;
    regBits_t  rd;
    word_t     aluOut;
    word_t     load;
  } mmWb_t;

endpackage

// File: registerFile.sv
//##########################################################################
// register file
//##########################################################################
`timescale 1ns/1ps

module registerFile
  import cpuTypesPkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regBits_t wsel,
  input  regBits_t rsel1,
  input  regBits_t rsel2,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  // register zero has no storage
  word_t regs [31:1];

  // falling edge write, decode reads it in the same cycle
  always_ff @(negedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// File: controlUnit.sv
//##########################################################################
// instruction decoder
//##########################################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlUnit
  import cpuTypesPkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // nop unless decoded below
    ctrl.regDst   = RT;
    ctrl.aluSrc   = 1'b1;
    ctrl.memToReg = ALUO;
    ctrl.regWen   = 1'b0;
    ctrl.dRen     = 1'b0;
    ctrl.dWen     = 1'b0;
    ctrl.aluOp    = ALU_ADD;
    ctrl.extOp    = SIGNEXT;
    ctrl.halt     = 1'b0;
    case (opcode)
      RTYPE: begin
        ctrl.regDst = RD;
        ctrl.aluSrc = 1'b0;
        ctrl.regWen = 1'b1;
        case (funct)
          ADDU: ctrl.aluOp = ALU_ADD;
          SUBU: ctrl.aluOp = ALU_SUB;
          AND:  ctrl.aluOp = ALU_AND;
          OR:   ctrl.aluOp = ALU_OR;
          XOR:  ctrl.aluOp = ALU_XOR;
          NOR:  ctrl.aluOp = ALU_NOR;
          SLT:  ctrl.aluOp = ALU_SLT;
          // shifts take the amount as the second operand
          SLL, SRL: begin
            ctrl.aluOp  = (funct == SLL) ? ALU_SLL : ALU_SRL;
            ctrl.aluSrc = 1'b1;
            ctrl.extOp  = SHAMEXT;
          end
          default: ctrl.regWen = 1'b0;
        endcase
      end
      ADDIU: ctrl.regWen = 1'b1;
      SLTI: begin
        ctrl.regWen = 1'b1;
        ctrl.aluOp  = ALU_SLT;
      end
      // logic immediates are zero extended
      ANDI, ORI, XORI, LUI: begin
        ctrl.regWen = 1'b1;
        ctrl.extOp  = ZEROEXT;
        case (opcode)
          ANDI:    ctrl.aluOp = ALU_AND;
          ORI:     ctrl.aluOp = ALU_OR;
          XORI:    ctrl.aluOp = ALU_XOR;
          default: ctrl.aluOp = ALU_LUI;
        endcase
      end
      LW: begin
        ctrl.regWen   = 1'b1;
        ctrl.memToReg = DLOAD;
        ctrl.dRen     = 1'b1;
      end
      SW:      ctrl.dWen = 1'b1;
      HALT:    ctrl.halt = (instr == `HALT_INSTR);
      default: ctrl.regWen = 1'b0;
    endcase
  end

endmodule

// File: alu.sv
//##########################################################################
// arithmetic logic unit
//##########################################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu
  import cpuTypesPkg::*;
(
  input  word_t  portA,
  input  word_t  portB,
  input  aluOp_t aluOp,
  output word_t  portO,
  output logic   zero
);

  // shift amount from the low bits of b
  logic [`SHAM_W-1:0] sham;

  assign sham = portB[`SHAM_W-1:0];

  always_comb begin
    case (aluOp)
      ALU_ADD: portO = portA + portB;
      ALU_SUB: portO = portA - portB;
      ALU_AND: portO = portA & portB;
      ALU_OR:  portO = portA | portB;
      ALU_XOR: portO = portA ^ portB;
      ALU_NOR: portO = ~(portA | portB);
      // signed compare
      ALU_SLT: portO = word_t'($signed(portA) < $signed(portB));
      ALU_SLL: portO = portA << sham;
      ALU_SRL: portO = portA >> sham;
      default: portO = portB << `IMM_W;
    endcase
  end

  assign zero = (portO == '0);

endmodule

// File: forwardingUnit.sv
//##########################################################################
// operand forwarding
//##########################################################################
`timescale 1ns/1ps

module forwardingUnit
  import cpuTypesPkg::*;
(
  input  regBits_t exRs,
  input  regBits_t exRt,
  input  regBits_t mmRd,
  input  regBits_t wbRd,
  input  logic     mmRegWen,
  input  logic     wbRegWen,
  output fwdSel_t  fwdA,
  output fwdSel_t  fwdB
);

  // memory stage is younger, so it wins over writeback
  function automatic fwdSel_t pickSrc(input regBits_t src);
    fwdSel_t sel;
    sel = FREG;
    if (mmRegWen && mmRd != '0 && mmRd == src) begin
      sel = FMM;
    end else if (wbRegWen && wbRd != '0 && wbRd == src) begin
      sel = FWB;
    end
    return sel;
  endfunction

  assign fwdA = pickSrc(exRs);
  assign fwdB = pickSrc(exRt);

endmodule

// File: datapath.sv
//##########################################################################
// five stage pipelined datapath
//##########################################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  logic  dhit,
  input  word_t imemload,
  input  word_t dmemload,
  output logic  halt,
  output logic  imemREN,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t imemaddr,
  output word_t dmemaddr,
  output word_t dmemstore
);

  word_t    pc;
  ifId_t    ifId;
  idEx_t    idEx;
  exMm_t    exMm;
  mmWb_t    mmWb;
  ctrl_t    idCtrl;
  word_t    rdat1, rdat2;
  word_t    imm32, fwdValA, fwdValB, aluA, aluB, aluOut, busW;
  fwdSel_t  fwdA, fwdB;
  regBits_t rw;
  logic     en, stopFetch;

  // whole pipe moves on either hit
  assign en = ihit | dhit;
  // a halt anywhere down the pipe stops new fetches
  assign stopFetch = idCtrl.halt | idEx.ctrl.halt | exMm.halt | mmWb.halt | halt;

  registerFile u_registerFile (
    .CLK(CLK), .nRST(nRST), .wen(mmWb.regWen), .wsel(mmWb.rd),
    .rsel1(ifId.instr[25:21]), .rsel2(ifId.instr[20:16]), .wdat(busW),
    .rdat1(rdat1), .rdat2(rdat2)
  );

  controlUnit u_controlUnit (.instr(ifId.instr), .ctrl(idCtrl));

  forwardingUnit u_forwardingUnit (
    .exRs(idEx.rs), .exRt(idEx.rt), .mmRd(exMm.rd), .wbRd(mmWb.rd),
    .mmRegWen(exMm.regWen), .wbRegWen(mmWb.regWen), .fwdA(fwdA), .fwdB(fwdB)
  );

  // zero flag unused until branches
  alu u_alu (.portA(aluA), .portB(aluB), .aluOp(idEx.ctrl.aluOp), .portO(aluOut), .zero());

  // fetch, pc only counts up
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `PC_INIT;
    end else if (ihit && !stopFetch) begin
      pc <= pc + word_t'(4);
    end
  end

  // bubble on dhit, the fetch is retried
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifId <= '0;
    end else if (en) begin
      ifId.instr <= (dhit || stopFetch) ? '0 : imemload;
    end
  end

  // decode to execute
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      idEx <= '0;
    end else if (en) begin
      idEx.ctrl  <= idCtrl;
      idEx.rs    <= ifId.instr[25:21];
      idEx.rt    <= ifId.instr[20:16];
      idEx.rd    <= ifId.instr[15:11];
      idEx.shamt <= ifId.instr[10:6];
      idEx.imm   <= ifId.instr[15:0];
      idEx.busA  <= rdat1;
      idEx.busB  <= rdat2;
    end
  end

  // immediate extender
  always_comb begin
    case (idEx.ctrl.extOp)
      SIGNEXT: imm32 = {{(`WORD_W-`IMM_W){idEx.imm[`IMM_W-1]}}, idEx.imm};
      SHAMEXT: imm32 = {{(`WORD_W-`SHAM_W){1'b0}}, idEx.shamt};
      default: imm32 = {{(`WORD_W-`IMM_W){1'b0}}, idEx.imm};
    endcase
  end

  // operand forwarding muxes
  always_comb begin
    case (fwdA)
      FMM:     fwdValA = exMm.aluOut;
      FWB:     fwdValA = busW;
      default: fwdValA = idEx.busA;
    endcase
    case (fwdB)
      FMM:     fwdValB = exMm.aluOut;
      FWB:     fwdValB = busW;
      default: fwdValB = idEx.busB;
    endcase
  end

  // shifts operate on rt, everything else on rs
  assign aluA = (idEx.ctrl.extOp == SHAMEXT) ? fwdValB : fwdValA;
  assign aluB = idEx.ctrl.aluSrc ? imm32 : fwdValB;
  assign rw   = (idEx.ctrl.regDst == RD) ? idEx.rd : idEx.rt;

  // execute to memory, store carries forwarded rt
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exMm <= '0;
    end else if (en) begin
      exMm.memToReg <= idEx.ctrl.memToReg;
      exMm.regWen   <= idEx.ctrl.regWen;
      exMm.dRen     <= idEx.ctrl.dRen;
      exMm.dWen     <= idEx.ctrl.dWen;
      exMm.halt     <= idEx.ctrl.halt;
      exMm.rd       <= rw;
      exMm.aluOut   <= aluOut;
      exMm.store    <= fwdValB;
    end
  end

  // memory to writeback, load valid on dhit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mmWb <= '0;
    end else if (en) begin
      mmWb.memToReg <= exMm.memToReg;
      mmWb.regWen   <= exMm.regWen;
      mmWb.halt     <= exMm.halt;
      mmWb.rd       <= exMm.rd;
      mmWb.aluOut   <= exMm.aluOut;
      mmWb.load     <= dmemload;
    end
  end

  assign busW = (mmWb.memToReg == DLOAD) ? mmWb.load : mmWb.aluOut;

  // memory port
  assign imemREN   = 1'b1;
  assign imemaddr  = pc;
  assign dmemREN   = exMm.dRen;
  assign dmemWEN   = exMm.dWen;
  assign dmemaddr  = exMm.aluOut;
  assign dmemstore = exMm.store;

  // sticky halt, cleared only by reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (mmWb.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// File: datapath_checker.sv
//##########################################################################
// datapath port assertions
//##########################################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapathChecker (
  input logic              CLK,
  input logic              nRST,
  input logic              halt,
  input logic              dmemREN,
  input logic              dmemWEN,
  input logic [`WORD_W-1:0] imemaddr
);

  // one data request kind at a time
  noReadWrite: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN))
    else $error("dmemREN and dmemWEN high together");

  // fetch address on a word boundary
  alignedFetch: assert property (@(posedge CLK) disable iff (!nRST)
    imemaddr[1:0] == 2'b00)
    else $error("imemaddr not word aligned");

  // halt is sticky until reset
  haltSticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else $error("halt fell without reset");

endmodule

// File: tbDatapath.sv
//##########################################################################
// pipelined datapath testbench
//##########################################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tbDatapath;

  logic CLK = 1'b0, nRST = 1'b0, ihit = 1'b0, dhit = 1'b0;
  logic [31:0] imemload = '0, dmemload = '0;
  logic halt, imemREN, dmemREN, dmemWEN;
  logic [31:0] imemaddr, dmemaddr, dmemstore;
  // unified memory with program at 0 and data from 0x800
  logic [31:0] mem [1024];
  logic [31:0] prog [$];
  logic [31:0] expAddr [256];
  logic [31:0] expData [256];
  logic [31:0] lcgState = 32'h47cc_594e;
  int expCount, storeIdx, testErr, errors, tests, failedTests;
  string testName;

  datapath u_datapath (.*);

  bind datapath datapathChecker u_datapathChecker (.CLK(CLK), .nRST(nRST), .halt(halt),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .imemaddr(imemaddr));

  always #20 CLK = ~CLK;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] encR(input int fn, input int rd, input int rs,
                                       input int rt, input int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
  endfunction

  function automatic logic [31:0] encI(input int op, input int rt, input int rs, input int imm);
    return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // sequential ISA model that fills the expected store list
  function automatic int refRun();
    logic [31:0] r [32];
    logic [31:0] dm [1024];
    logic [31:0] pc, ins, a, b, se, ze, res, addr;
    int n, dst;
    logic wr;
    n = 0;
    pc = `PC_INIT;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 1024; i++) dm[i] = mem[i];
    for (int step = 0; step < 512; step++) begin
      ins = dm[pc[11:2]];
      if (ins == `HALT_INSTR) break;
      a = r[ins[25:21]];
      b = r[ins[20:16]];
      se = {{16{ins[15]}}, ins[15:0]};
      ze = {16'h0000, ins[15:0]};
      addr = a + se;
      wr = 1'b1;
      dst = int'(ins[20:16]);
      res = '0;
      case (ins[31:26])
        6'h00: begin
          dst = int'(ins[15:11]);
          case (ins[5:0])
            6'h21: res = a + b;
            6'h23: res = a - b;
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h26: res = a ^ b;
            6'h27: res = ~(a | b);
            6'h2A: res = {31'b0, $signed(a) < $signed(b)};
            6'h00: res = b << ins[10:6];
            6'h02: res = b >> ins[10:6];
            default: wr = 1'b0;
          endcase
        end
        6'h09: res = a + se;
        6'h0A: res = {31'b0, $signed(a) < $signed(se)};
        6'h0C: res = a & ze;
        6'h0D: res = a | ze;
        6'h0E: res = a ^ ze;
        6'h0F: res = {ins[15:0], 16'h0000};
        6'h23: res = dm[addr[11:2]];
        6'h2B: begin
          wr = 1'b0;
          dm[addr[11:2]] = b;
          expAddr[n] = addr;
          expData[n] = b;
          n++;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != 0) r[dst] = res;
      pc = pc + 32'd4;
    end
    return n;
  endfunction

  // memory model answers on the falling edge and checks each store
  always @(negedge CLK) begin
    if (dmemREN || dmemWEN) begin
      ihit <= 1'b0;
      dhit <= 1'b1;
      imemload <= '0;
      dmemload <= mem[dmemaddr[11:2]];
      if (dmemWEN) begin
        mem[dmemaddr[11:2]] = dmemstore;
        if (storeIdx >= expCount) begin
          $display("%s: unexpected store of %h to %h", testName, dmemstore, dmemaddr);
          testErr++;
        end else begin
          if (dmemaddr !== expAddr[storeIdx]) begin
            $display("CHECK FAILED %s store %0d address: expected %h actual %h",
                     testName, storeIdx, expAddr[storeIdx], dmemaddr);
            testErr++;
          end
          if (dmemstore !== expData[storeIdx]) begin
            $display("CHECK FAILED %s store %0d data: expected %h actual %h",
                     testName, storeIdx, expData[storeIdx], dmemstore);
            testErr++;
          end
        end
        storeIdx++;
      end
    end else begin
      // instruction fetch is always requested
      if (imemREN !== 1'b1) begin
        $display("CHECK FAILED %s imemREN: expected 1 actual %b", testName, imemREN);
        testErr++;
      end
      ihit <= 1'b1;
      dhit <= 1'b0;
      imemload <= mem[imemaddr[11:2]];
      dmemload <= '0;
    end
  end

  // checks the port state on every reset cycle and at release
  task automatic applyReset();
    @(negedge CLK);
    nRST = 1'b0;
    for (int c = 1; c <= 8; c++) begin
      @(negedge CLK);
      if (c == 8) nRST = 1'b1;
      if (halt !== 1'b0 || dmemREN !== 1'b0 || dmemWEN !== 1'b0 || imemaddr !== `PC_INIT) begin
        $display("CHECK FAILED %s reset hlt/ren/wen/pc: expected 0 0 0 %h actual %b %b %b %h",
                 testName, `PC_INIT, halt, dmemREN, dmemWEN, imemaddr);
        testErr++;
      end
    end
  endtask

  // loads prog, runs it to halt and checks the store count
  task automatic runProgram(input string name, input int holdCycles);
    int c;
    testName = name;
    testErr = 0;
    storeIdx = 0;
    for (int i = 0; i < 1024; i++) mem[i] = i * 32'h9E37_79B9 + 32'h1357_2468;
    foreach (prog[i]) mem[i] = prog[i];
    expCount = refRun();
    applyReset();
    for (c = 0; c < 2000 && !halt; c++) @(negedge CLK);
    if (!halt) begin
      $display("%s: timeout, halt never rose", name);
      testErr++;
    end
    // halt must hold and nothing may follow it
    for (c = 0; c < holdCycles; c++) begin
      @(negedge CLK);
      if (!halt) begin
        $display("%s: halt dropped after rising", name);
        testErr++;
      end
    end
    if (storeIdx != expCount) begin
      $display("CHECK FAILED %s store count: expected %0d actual %0d", name, expCount, storeIdx);
      testErr++;
    end
    tests++;
    errors += testErr;
    if (testErr == 0) begin
      $display("test %s passed, %0d stores", name, storeIdx);
    end else begin
      $display("test %s failed with %0d errors", name, testErr);
      failedTests++;
    end
    prog.delete();
  endtask

  task automatic storeRegs(input int first, input int last);
    for (int k = first; k <= last; k++) prog.push_back(encI('h2B, k, 0, 'h800 + 4 * k));
    prog.push_back(`HALT_INSTR);
  endtask

  initial begin
    int kind, rd, rs, rt;
    // dependent chain at distance one and two
    prog = '{encI('h09, 1, 0, 5), encI('h09, 2, 0, 7), encR('h21, 3, 1, 2, 0),
             encR('h23, 4, 3, 2, 0), encR('h24, 5, 4, 3, 0), encR('h25, 6, 5, 4, 0),
             encR('h26, 7, 6, 5, 0), encR('h27, 8, 7, 6, 0), encR('h2A, 9, 8, 7, 0)};
    storeRegs(1, 9);
    runProgram("reset_and_chain", 0);
    prog = '{encI('h09, 1, 0, 'hFFFD), encI('h0C, 2, 1, 'h8F0F), encI('h0D, 3, 0, 'h8001),
             encI('h0F, 4, 0, 'h8765), encI('h0D, 4, 4, 'h4321), encR('h00, 5, 0, 4, 4),
             encR('h02, 6, 0, 4, 31), encI('h0A, 7, 1, 'hFFFF)};
    storeRegs(1, 7);
    runProgram("immediates", 0);
    // load after store with a spacer before each use
    prog = '{encI('h09, 1, 0, 'h1234), encI('h2B, 1, 0, 'h900), encI('h23, 2, 0, 'h900),
             encI('h09, 3, 0, 1), encR('h21, 4, 2, 3, 0), encI('h2B, 4, 0, 'h904),
             encI('h23, 5, 0, 'hA00), encI('h09, 6, 0, 3), encR('h26, 6, 5, 4, 0),
             encI('h2B, 6, 0, 'h908)};
    storeRegs(1, 6);
    runProgram("load_store", 0);
    for (int p = 0; p < 20; p++) begin
      for (int i = 0; i < 24; i++) begin
        lcgState = lcgNext(lcgState);
        kind = int'((lcgState >> 16) % 32'd15);
        rd = 1 + int'((lcgState >> 8) % 32'd7);
        rs = int'((lcgState >> 4) & 32'd7);
        rt = int'(lcgState[2:0]);
        if (kind < 9) begin
          case (kind)
            0: prog.push_back(encR('h21, rd, rs, rt, 0));
            1: prog.push_back(encR('h23, rd, rs, rt, 0));
            2: prog.push_back(encR('h24, rd, rs, rt, 0));
            3: prog.push_back(encR('h25, rd, rs, rt, 0));
            4: prog.push_back(encR('h26, rd, rs, rt, 0));
            5: prog.push_back(encR('h27, rd, rs, rt, 0));
            6: prog.push_back(encR('h2A, rd, rs, rt, 0));
            7: prog.push_back(encR('h00, rd, 0, rt, int'(lcgState[31:27])));
            default: prog.push_back(encR('h02, rd, 0, rt, int'(lcgState[31:27])));
          endcase
        end else begin
          case (kind)
            9: prog.push_back(encI('h09, rd, rs, int'(lcgState[31:16])));
            10: prog.push_back(encI('h0C, rd, rs, int'(lcgState[31:16])));
            11: prog.push_back(encI('h0D, rd, rs, int'(lcgState[31:16])));
            12: prog.push_back(encI('h0E, rd, rs, int'(lcgState[31:16])));
            13: prog.push_back(encI('h0A, rd, rs, int'(lcgState[31:16])));
            default: prog.push_back(encI('h0F, rd, 0, int'(lcgState[31:16])));
          endcase
        end
      end
      storeRegs(1, 7);
      runProgram($sformatf("random_%0d", p), 0);
    end
    // stores placed after the halt word must never show up
    prog = '{encI('h09, 1, 0, 9), encI('h2B, 1, 0, 'h800), `HALT_INSTR,
             encI('h2B, 1, 0, 'h804), encI('h2B, 1, 0, 'h808)};
    runProgram("halt", 20);
    $display("tests %0d, failed %0d, errors %0d", tests, failedTests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
cpuTypesPkg.sv
registerFile.sv
controlUnit.sv
alu.sv
forwardingUnit.sv
datapath.sv
datapath_checker.sv
tbDatapath.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tbDatapath -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
